//--- hw/pg_pkg.sv
`default_nettype none

package pg_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  // Phase and step width
  localparam int PHASE_W   = 16;
  // Entry word holds start phase over step
  localparam int ENTRY_W   = 2 * PHASE_W;
  // 32 entries
  localparam int ENTRY_AW  = 5;
  // 64 coefficients per lane
  localparam int COEF_AW   = 6;
  localparam int TWIDDLE_W = 64;
  localparam int LANES     = 4;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // Host configuration strobe
  typedef struct packed {
    logic                 wr_entry;
    logic                 wr_coef;
    // Entry table decodes the low ENTRY_AW bits only
    logic [COEF_AW-1:0]   addr;
    // Entry write: [31:16] start phase, [15:0] step
    logic [TWIDDLE_W-1:0] data;
  } cfg_t;

  // Per-lane frame setup
  typedef struct packed {
    logic [PHASE_W-1:0] phase;
    logic [PHASE_W-1:0] inc;
  } lane_base_t;

  // Beat control
  typedef struct packed {
    logic valid;
    logic last;
  } ctrl_t;

  // Lane 0 in the low word
  typedef logic [LANES-1:0][TWIDDLE_W-1:0] twiddle_vec_t;

endpackage

`default_nettype wire

//--- hw/delay_line.sv
`timescale 1ns/100ps
`default_nettype none

module delay_line #(
  parameter type T     = logic,
  parameter int  DEPTH = 1
) (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  T i_d,
  output T       o_q
);

  // Stage 0 takes the input, the last stage drives the output
  T stage_q [DEPTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= i_d;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign o_q = stage_q[DEPTH-1];

endmodule

`default_nettype wire

//--- hw/phase_entry_decode.sv
`timescale 1ns/100ps
`default_nettype none

module phase_entry_decode (
  input  wire                                    clk,
  input  wire                                    rst_n,
  input  wire pg_pkg::cfg_t                      i_cfg,
  input  wire [pg_pkg::ENTRY_AW-1:0]             i_entry_sel,
  output pg_pkg::cfg_t                           o_cfg,
  output pg_pkg::lane_base_t [pg_pkg::LANES-1:0] o_base
);

  logic [pg_pkg::ENTRY_W-1:0] entry_mem [2**pg_pkg::ENTRY_AW];
  logic [pg_pkg::ENTRY_W-1:0] entry_q;
  logic [pg_pkg::PHASE_W-1:0] start_phase;
  logic [pg_pkg::PHASE_W-1:0] step;

  //////////////////////////////////////////////////
  // Host strobe staging
  //////////////////////////////////////////////////

  // One register stage, shared with the lanes for coefficient writes
  delay_line #(
    .T     (pg_pkg::cfg_t),
    .DEPTH (1)
  ) u_cfg_stage (
    .clk   (clk),
    .rst_n (rst_n),
    .i_d   (i_cfg),
    .o_q   (o_cfg)
  );

  //////////////////////////////////////////////////
  // Entry table
  //////////////////////////////////////////////////

  // Single port: a staged write wins, the select read waits
  always_ff @(posedge clk) begin
    if (o_cfg.wr_entry) begin
      entry_mem[o_cfg.addr[pg_pkg::ENTRY_AW-1:0]] <= o_cfg.data[pg_pkg::ENTRY_W-1:0];
    end else begin
      entry_q <= entry_mem[i_entry_sel];
    end
  end

  assign start_phase = entry_q[pg_pkg::ENTRY_W-1:pg_pkg::PHASE_W];
  assign step        = entry_q[pg_pkg::PHASE_W-1:0];

  //////////////////////////////////////////////////
  // Lane base split
  //////////////////////////////////////////////////

  // Lane k starts k steps in, all lanes stride four steps
  always_comb begin
    logic [pg_pkg::PHASE_W-1:0] lane_off;
    lane_off = '0;
    for (int k = 0; k < pg_pkg::LANES; k++) begin
      o_base[k].phase = start_phase + lane_off;
      o_base[k].inc   = step << 2;
      lane_off        = lane_off + step;
    end
  end

endmodule

`default_nettype wire

//--- hw/phase_lane_execute.sv
`timescale 1ns/100ps
`default_nettype none

module phase_lane_execute (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire pg_pkg::cfg_t            i_cfg,
  input  wire                          i_start,
  input  wire pg_pkg::ctrl_t           i_beat,
  input  wire pg_pkg::lane_base_t      i_base,
  output logic [pg_pkg::TWIDDLE_W-1:0] o_twiddle
);

  logic [pg_pkg::TWIDDLE_W-1:0] coef_mem [2**pg_pkg::COEF_AW];
  logic [pg_pkg::PHASE_W-1:0]   phase_q;
  logic [pg_pkg::PHASE_W-1:0]   inc_q;
  logic [pg_pkg::PHASE_W-1:0]   cur_phase;
  logic [pg_pkg::PHASE_W-1:0]   cur_inc;
  logic [pg_pkg::COEF_AW-1:0]   coef_addr;

  //////////////////////////////////////////////////
  // Phase accumulator
  //////////////////////////////////////////////////

  // Start bypasses the accumulator so a beat in the same cycle
  // already sees the new base
  assign cur_phase = i_start ? i_base.phase : phase_q;
  assign cur_inc   = i_start ? i_base.inc : inc_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= '0;
      inc_q   <= '0;
    end else begin
      if (i_start || i_beat.valid) begin
        inc_q <= cur_inc;
      end
      // Advance only on valid beats
      if (i_beat.valid) begin
        phase_q <= cur_phase + cur_inc;
      end else if (i_start) begin
        phase_q <= i_base.phase;
      end
    end
  end

  //////////////////////////////////////////////////
  // Coefficient table
  //////////////////////////////////////////////////

  // Top bits of the phase pick the twiddle
  assign coef_addr = cur_phase[pg_pkg::PHASE_W-1 -: pg_pkg::COEF_AW];

  // Every lane receives the same host write
  always_ff @(posedge clk) begin
    if (i_cfg.wr_coef) begin
      coef_mem[i_cfg.addr] <= i_cfg.data;
    end
  end

  // Registered lookup, host write has the port first
  // Holds the last word between beats
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_twiddle <= '0;
    end else if (i_beat.valid && !i_cfg.wr_coef) begin
      o_twiddle <= coef_mem[coef_addr];
    end
  end

endmodule

`default_nettype wire

//--- hw/twiddle_result.sv
`timescale 1ns/100ps
`default_nettype none

module twiddle_result (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire pg_pkg::twiddle_vec_t  i_twiddle,
  input  wire pg_pkg::ctrl_t         i_beat,
  output pg_pkg::twiddle_vec_t       o_twiddle,
  output pg_pkg::ctrl_t              o_beat
);

  //////////////////////////////////////////////////
  // Data
  //////////////////////////////////////////////////

  // Lane words land here one cycle after the lookup
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_twiddle <= '0;
    end else begin
      o_twiddle <= i_twiddle;
    end
  end

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  // Two stages: lane lookup plus the output register above
  delay_line #(
    .T     (pg_pkg::ctrl_t),
    .DEPTH (2)
  ) u_beat_delay (
    .clk   (clk),
    .rst_n (rst_n),
    .i_d   (i_beat),
    .o_q   (o_beat)
  );

endmodule

`default_nettype wire

//--- hw/phase_gen_top.sv
`timescale 1ns/100ps
`default_nettype none

module phase_gen_top (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire pg_pkg::cfg_t           i_cfg,
  input  wire [pg_pkg::ENTRY_AW-1:0]  i_entry_sel,
  input  wire                         i_start,
  input  wire pg_pkg::ctrl_t          i_beat,
  output pg_pkg::twiddle_vec_t        o_twiddle,
  output pg_pkg::ctrl_t               o_beat
);

  pg_pkg::cfg_t                           stage_cfg;
  pg_pkg::lane_base_t [pg_pkg::LANES-1:0] lane_base;
  pg_pkg::twiddle_vec_t                   lane_twiddle;

  //////////////////////////////////////////////////
  // Entry decode
  //////////////////////////////////////////////////

  phase_entry_decode u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_cfg       (i_cfg),
    .i_entry_sel (i_entry_sel),
    .o_cfg       (stage_cfg),
    .o_base      (lane_base)
  );

  //////////////////////////////////////////////////
  // Execute lanes
  //////////////////////////////////////////////////

  for (genvar g = 0; g < pg_pkg::LANES; g++) begin : g_lane
    phase_lane_execute u_lane (
      .clk       (clk),
      .rst_n     (rst_n),
      .i_cfg     (stage_cfg),
      .i_start   (i_start),
      .i_beat    (i_beat),
      .i_base    (lane_base[g]),
      .o_twiddle (lane_twiddle[g])
    );
  end

  //////////////////////////////////////////////////
  // Result stage
  //////////////////////////////////////////////////

  twiddle_result u_result (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_twiddle (lane_twiddle),
    .i_beat    (i_beat),
    .o_twiddle (o_twiddle),
    .o_beat    (o_beat)
  );

endmodule

`default_nettype wire

//--- dv/phase_gen_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module phase_gen_asserts (
  input wire                       clk,
  input wire                       rst_n,
  input wire pg_pkg::ctrl_t        i_in_beat,
  input wire pg_pkg::ctrl_t        i_out_beat,
  input wire pg_pkg::twiddle_vec_t i_out_twiddle
);

  //////////////////////////////////////////////////
  // Reset and output framing
  //////////////////////////////////////////////////

  // By the second reset cycle every flop has been cleared
  a_reset_zero: assert property (
    @(posedge clk) (!rst_n ##1 !rst_n) |-> (i_out_beat == '0 && i_out_twiddle == '0)
  ) else $error("outputs not cleared during reset");

  a_last_needs_valid: assert property (
    @(posedge clk) disable iff (!rst_n) i_out_beat.last |-> i_out_beat.valid
  ) else $error("last flag without valid on the output");

  // Lane lookup plus result register
  a_valid_latency: assert property (
    @(posedge clk) disable iff (!rst_n) i_out_beat.valid == $past(i_in_beat.valid, 2)
  ) else $error("output valid does not follow input valid by two cycles");

endmodule

bind phase_gen_top phase_gen_asserts u_asserts (
  .clk           (clk),
  .rst_n         (rst_n),
  .i_in_beat     (i_beat),
  .i_out_beat    (o_beat),
  .i_out_twiddle (o_twiddle)
);

`default_nettype wire

//--- dv/phase_gen_tb.sv
`timescale 1ns/100ps
`default_nettype none

module phase_gen_tb;

  localparam logic [31:0] SEED = 32'h5b7281a5;
  localparam int NUM_ENTRIES = 2**pg_pkg::ENTRY_AW;
  localparam int NUM_COEFS   = 2**pg_pkg::COEF_AW;
  localparam int NUM_FRAMES  = 7;
  localparam int MAX_BEATS   = 24;
  localparam int MAX_GAP     = 3;
  // Four cycles per host write, a few rewrites on top of the full load
  localparam int LOAD_CYCLES    = 4 * (NUM_ENTRIES + NUM_COEFS + 8);
  localparam int FRAME_CYCLES   = NUM_FRAMES * (MAX_BEATS * (MAX_GAP + 1) + 12);
  localparam int TIMEOUT_CYCLES = 4 + LOAD_CYCLES + FRAME_CYCLES + 200;

  logic                         clk;
  logic                         rst_n;
  pg_pkg::cfg_t                 cfg;
  logic [pg_pkg::ENTRY_AW-1:0]  entry_sel;
  logic                         start;
  pg_pkg::ctrl_t                beat;
  pg_pkg::twiddle_vec_t         twiddle;
  pg_pkg::ctrl_t                out_beat;

  // Model copies of both tables
  logic [pg_pkg::ENTRY_W-1:0]   entry_model [NUM_ENTRIES];
  logic [pg_pkg::TWIDDLE_W-1:0] coef_model [NUM_COEFS];
  pg_pkg::twiddle_vec_t         exp_q [$];

  phase_gen_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_cfg       (cfg),
    .i_entry_sel (entry_sel),
    .i_start     (start),
    .i_beat      (beat),
    .o_twiddle   (twiddle),
    .o_beat      (out_beat)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Lane k at beat n sits at start + k*step + 4n*step, wrapping at 16 bits
  function automatic logic [pg_pkg::TWIDDLE_W-1:0] ref_twiddle(
    input logic [pg_pkg::ENTRY_W-1:0] entry,
    input int                         lane,
    input int                         n
  );
    logic [pg_pkg::PHASE_W-1:0] step;
    logic [pg_pkg::PHASE_W-1:0] phase;
    step  = entry[pg_pkg::PHASE_W-1:0];
    phase = entry[pg_pkg::ENTRY_W-1:pg_pkg::PHASE_W] + 16'(lane * step) + 16'(4 * n * step);
    return coef_model[phase[pg_pkg::PHASE_W-1 -: pg_pkg::COEF_AW]];
  endfunction

  function automatic pg_pkg::twiddle_vec_t expected_vec(
    input logic [pg_pkg::ENTRY_W-1:0] entry,
    input int                         n
  );
    pg_pkg::twiddle_vec_t vec;
    for (int k = 0; k < pg_pkg::LANES; k++) begin
      vec[k] = ref_twiddle(entry, k, n);
    end
    return vec;
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_twiddle(input pg_pkg::twiddle_vec_t got,
                               input pg_pkg::twiddle_vec_t exp, input string what);
    if (got !== exp) begin
      $display("Fail at time %0d ns: %s twiddle got %h expected %h", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1, "twiddle mismatch");
    end
  endtask

  task automatic check_ctrl(input pg_pkg::ctrl_t got, input pg_pkg::ctrl_t exp);
    if (got !== exp) begin
      $display("Fail at time %0d ns: o_beat got %b expected %b", $time, got, exp);
      $display("Checks failed");
      $fatal(1, "beat control mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // Host writes and frames
  //////////////////////////////////////////////////

  task automatic host_write(input logic wr_entry, input logic [pg_pkg::COEF_AW-1:0] addr,
                            input logic [pg_pkg::TWIDDLE_W-1:0] data);
    pg_pkg::cfg_t c;
    c          = '0;
    c.wr_entry = wr_entry;
    c.wr_coef  = !wr_entry;
    c.addr     = addr;
    c.data     = data;
    @(posedge clk);
    cfg <= c;
    @(posedge clk);
    cfg <= '0;
    // Staged write lands, then the entry read resumes
    repeat (2) @(posedge clk);
  endtask

  task automatic write_entry(input int addr, input logic [15:0] start_phase,
                             input logic [15:0] step);
    entry_model[addr] = {start_phase, step};
    host_write(1'b1, 6'(addr), 64'({start_phase, step}));
  endtask

  task automatic write_coef(input int addr, input logic [pg_pkg::TWIDDLE_W-1:0] data);
    coef_model[addr] = data;
    host_write(1'b0, 6'(addr), data);
  endtask

  task automatic run_frame(input int sel, input int nbeats, input bit gaps);
    logic [pg_pkg::ENTRY_W-1:0] entry;
    int                         idle;
    entry = entry_model[sel];
    @(posedge clk);
    entry_sel <= 5'(sel);
    // Select settles two cycles ahead of the start pulse
    repeat (2) @(posedge clk);
    if (gaps) begin
      start <= 1'b1;
      beat  <= '0;
      @(posedge clk);
    end
    for (int n = 0; n < nbeats; n++) begin
      idle = gaps ? int'($urandom_range(MAX_GAP)) : 0;
      for (int i = 0; i < idle; i++) begin
        start <= 1'b0;
        beat  <= '0;
        @(posedge clk);
      end
      start      <= (n == 0) && !gaps;
      beat.valid <= 1'b1;
      beat.last  <= (n == nbeats - 1);
      exp_q.push_back(expected_vec(entry, n));
      @(posedge clk);
    end
    start <= 1'b0;
    beat  <= '0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
  endtask

  //////////////////////////////////////////////////
  // Output checker
  //////////////////////////////////////////////////

  // Sampled at the falling edge, where every output is stable
  initial begin : compare_outputs
    pg_pkg::ctrl_t        beat_hist [3];
    pg_pkg::twiddle_vec_t last_vec;
    pg_pkg::twiddle_vec_t exp_vec;
    for (int i = 0; i < 3; i++) begin
      beat_hist[i] = '0;
    end
    last_vec = '0;
    // First edge clears the flops
    @(posedge clk);
    forever begin
      @(negedge clk);
      beat_hist[2] = beat_hist[1];
      beat_hist[1] = beat_hist[0];
      beat_hist[0] = beat;
      check_ctrl(out_beat, beat_hist[2]);
      if (!out_beat.valid) begin
        check_twiddle(twiddle, last_vec, "held");
      end else if (exp_q.size() == 0) begin
        $display("An output beat came out at %0d ns with no input beat pending", $time);
        $display("Checks failed");
        $fatal(1, "unexpected output beat");
      end else begin
        exp_vec = exp_q.pop_front();
        check_twiddle(twiddle, exp_vec, "valid beat");
        last_vec = exp_vec;
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the frames did not complete", TIMEOUT_CYCLES);
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin : stimulus
    void'($urandom(SEED));
    rst_n     = 1'b0;
    cfg       = '0;
    entry_sel = '0;
    start     = 1'b0;
    beat      = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    for (int a = 0; a < NUM_ENTRIES; a++) begin
      write_entry(a, 16'($urandom), 16'($urandom));
    end
    for (int a = 0; a < NUM_COEFS; a++) begin
      write_coef(a, {$urandom, $urandom});
    end

    // Back to back, then with gaps
    run_frame(3, 20, 1'b0);
    run_frame(17, 16, 1'b1);
    run_frame(int'($urandom_range(NUM_ENTRIES - 1)), MAX_BEATS, 1'b0);

    // New entries with steps that wrap
    write_entry(9, 16'he100, 16'hf3a1);
    write_entry(22, 16'h7ff0, 16'h9c4d);
    run_frame(22, 18, 1'b0);
    run_frame(9, 12, 1'b1);

    // Word under entry 3's first phase plus a few others
    write_coef(int'(entry_model[3][31:26]), {$urandom, $urandom});
    for (int i = 0; i < 3; i++) begin
      write_coef(int'($urandom_range(NUM_COEFS - 1)), {$urandom, $urandom});
    end
    run_frame(3, 20, 1'b0);
    run_frame(22, MAX_BEATS, 1'b1);

    repeat (4) @(posedge clk);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
hw/pg_pkg.sv
hw/delay_line.sv
hw/phase_entry_decode.sv
hw/phase_lane_execute.sv
hw/twiddle_result.sv
hw/phase_gen_top.sv
dv/phase_gen_asserts.sv
dv/phase_gen_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := phase_gen_tb
FILELIST := filelist.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "Result: run ended early"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
